//--- source/irq_pkg.sv
package irq_pkg;

  // ##################################################
  // Widths
  // ##################################################

  // Register data width of the RV32 hart
  localparam int unsigned xlen = 32;
  // Register index width on the shared bus
  localparam int unsigned addr_w = 4;

  // ##################################################
  // Register indices
  // ##################################################

  // Owned by the CSR bank
  localparam logic [addr_w-1:0] reg_mstatus     = 4'd0;
  localparam logic [addr_w-1:0] reg_mie         = 4'd1;
  localparam logic [addr_w-1:0] reg_mideleg     = 4'd2;
  localparam logic [addr_w-1:0] reg_mip         = 4'd3;
  localparam logic [addr_w-1:0] reg_priv        = 4'd4;
  localparam logic [addr_w-1:0] reg_menvcfgh    = 4'd5;
  localparam logic [addr_w-1:0] reg_mcounteren  = 4'd6;
  localparam logic [addr_w-1:0] reg_stimecmp    = 4'd7;
  localparam logic [addr_w-1:0] reg_stimecmph   = 4'd8;
  // Owned by the machine timer
  localparam logic [addr_w-1:0] reg_mtime_lo    = 4'd9;
  localparam logic [addr_w-1:0] reg_mtime_hi    = 4'd10;
  localparam logic [addr_w-1:0] reg_mtimecmp_lo = 4'd11;
  localparam logic [addr_w-1:0] reg_mtimecmp_hi = 4'd12;

  // Interrupt bits in mip, mie and mideleg
  localparam int unsigned ssip_bit = 1;
  localparam int unsigned msip_bit = 3;
  localparam int unsigned stip_bit = 5;
  localparam int unsigned mtip_bit = 7;
  localparam int unsigned seip_bit = 9;
  localparam int unsigned meip_bit = 11;

  // Status and enable fields
  localparam int unsigned mstatus_sie_bit   = 1;
  localparam int unsigned mstatus_mie_bit   = 3;
  localparam int unsigned menvcfgh_stce_bit = 31;
  localparam int unsigned mcounteren_tm_bit = 1;

  // Privilege encodings, code 2 is reserved
  localparam logic [1:0] priv_u    = 2'd0;
  localparam logic [1:0] priv_s    = 2'd1;
  localparam logic [1:0] priv_rsvd = 2'd2;
  localparam logic [1:0] priv_m    = 2'd3;

  // Software-writable mip bits
  localparam logic [xlen-1:0] mip_sw_mask = (32'd1 << ssip_bit) | (32'd1 << stip_bit);

  // Interrupt cause codes
  localparam logic [3:0] cause_ssi = 4'd1;
  localparam logic [3:0] cause_msi = 4'd3;
  localparam logic [3:0] cause_sti = 4'd5;
  localparam logic [3:0] cause_mti = 4'd7;
  localparam logic [3:0] cause_sei = 4'd9;
  localparam logic [3:0] cause_mei = 4'd11;

endpackage

//--- source/reg_bus_arbiter.sv
`timescale 1ns/100ps

module reg_bus_arbiter import irq_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // Hart CSR port
  input  logic            cpu_req,
  input  logic            cpu_we,
  input  logic [addr_w-1:0] cpu_addr,
  input  logic [xlen-1:0] cpu_wdata,
  output logic            cpu_gnt,
  output logic [xlen-1:0] cpu_rdata,
  output logic            cpu_rvalid,
  // Debug or host port
  input  logic            host_req,
  input  logic            host_we,
  input  logic [addr_w-1:0] host_addr,
  input  logic [xlen-1:0] host_wdata,
  output logic            host_gnt,
  output logic [xlen-1:0] host_rdata,
  output logic            host_rvalid,
  // Shared register bus
  output logic            bus_we,
  output logic [addr_w-1:0] bus_addr,
  output logic [xlen-1:0] bus_wdata,
  input  logic [xlen-1:0] bus_rdata
);

  // Host held the last grant
  logic            last_host;
  logic            any_gnt;
  logic [xlen-1:0] rdata_q;

  // Round robin, cpu wins unless host is owed a turn
  assign cpu_gnt  = cpu_req & (~host_req | last_host);
  assign host_gnt = host_req & ~cpu_gnt;
  assign any_gnt  = cpu_gnt | host_gnt;

  // Winner drives the bus
  assign bus_we    = (cpu_gnt & cpu_we) | (host_gnt & host_we);
  assign bus_addr  = host_gnt ? host_addr : cpu_addr;
  assign bus_wdata = host_gnt ? host_wdata : cpu_wdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Host counts as last so cpu wins the first contention
      last_host   <= 1'b1;
      cpu_rvalid  <= 1'b0;
      host_rvalid <= 1'b0;
    end else begin
      if (any_gnt) begin
        last_host <= host_gnt;
      end
      cpu_rvalid  <= cpu_gnt;
      host_rvalid <= host_gnt;
    end
  end

  // Read data sampled at the end of the grant cycle
  always_ff @(posedge clk) begin
    if (any_gnt) begin
      rdata_q <= bus_rdata;
    end
  end

  // Only the granted master sees the data
  assign cpu_rdata  = cpu_rvalid ? rdata_q : '0;
  assign host_rdata = host_rvalid ? rdata_q : '0;

endmodule

//--- source/irq_csr_bank.sv
`timescale 1ns/100ps

module irq_csr_bank import irq_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // Shared register bus
  input  logic              bus_we,
  input  logic [addr_w-1:0] bus_addr,
  input  logic [xlen-1:0]   bus_wdata,
  output logic [xlen-1:0]   csr_rdata,
  // From the interrupt controller
  input  logic [xlen-1:0]   mip_next,
  // CSR state
  output logic [xlen-1:0]   mstatus,
  output logic [xlen-1:0]   mie,
  output logic [xlen-1:0]   mideleg,
  output logic [xlen-1:0]   mip,
  output logic [1:0]        priv,
  output logic [xlen-1:0]   menvcfgh,
  output logic [xlen-1:0]   mcounteren,
  output logic [xlen-1:0]   stimecmp,
  output logic [xlen-1:0]   stimecmph
);

  logic            stce;
  logic [xlen-1:0] mip_wmask;
  logic [xlen-1:0] mip_wr;

  // ##################################################
  // mip write masking
  // ##################################################

  // Sstc owns STIP once STCE is set
  assign stce = menvcfgh[menvcfgh_stce_bit];

  always_comb begin
    mip_wmask = mip_sw_mask;
    if (stce) begin
      mip_wmask[stip_bit] = 1'b0;
    end
  end

  // Software bits from the bus, the rest from the controller
  assign mip_wr = (mip_next & ~mip_wmask) | (bus_wdata & mip_wmask);

  // ##################################################
  // Register file
  // ##################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus    <= '0;
      mie        <= '0;
      mideleg    <= '0;
      mip        <= '0;
      priv       <= priv_m;
      menvcfgh   <= '0;
      mcounteren <= '0;
      stimecmp   <= '1;
      stimecmph  <= '1;
    end else begin
      // Hardware view every cycle
      mip <= mip_next;
      if (bus_we) begin
        case (bus_addr)
          reg_mstatus:    mstatus    <= bus_wdata;
          reg_mie:        mie        <= bus_wdata;
          reg_mideleg:    mideleg    <= bus_wdata;
          reg_mip:        mip        <= mip_wr;
          reg_menvcfgh:   menvcfgh   <= bus_wdata;
          reg_mcounteren: mcounteren <= bus_wdata;
          reg_stimecmp:   stimecmp   <= bus_wdata;
          reg_stimecmph:  stimecmph  <= bus_wdata;
          reg_priv: begin
            // Reserved mode code dropped
            if (bus_wdata[1:0] != priv_rsvd) begin
              priv <= bus_wdata[1:0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Read mux, zero for timer indices
  always_comb begin
    case (bus_addr)
      reg_mstatus:    csr_rdata = mstatus;
      reg_mie:        csr_rdata = mie;
      reg_mideleg:    csr_rdata = mideleg;
      reg_mip:        csr_rdata = mip;
      reg_priv:       csr_rdata = {{(xlen-2){1'b0}}, priv};
      reg_menvcfgh:   csr_rdata = menvcfgh;
      reg_mcounteren: csr_rdata = mcounteren;
      reg_stimecmp:   csr_rdata = stimecmp;
      reg_stimecmph:  csr_rdata = stimecmph;
      default:        csr_rdata = '0;
    endcase
  end

endmodule

//--- source/machine_timer.sv
`timescale 1ns/100ps

module machine_timer import irq_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // Shared register bus
  input  logic              bus_we,
  input  logic [addr_w-1:0] bus_addr,
  input  logic [xlen-1:0]   bus_wdata,
  output logic [xlen-1:0]   timer_rdata,
  // Timer state
  output logic [63:0]       mtime,
  output logic              mtip
);

  logic [63:0] mtimecmp;

  // ##################################################
  // Counter and compare
  // ##################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtime    <= '0;
      mtimecmp <= '1;
    end else begin
      // A written word replaces the count for that edge
      if (bus_we && bus_addr == reg_mtime_lo) begin
        mtime <= {mtime[63:32], bus_wdata};
      end else if (bus_we && bus_addr == reg_mtime_hi) begin
        mtime <= {bus_wdata, mtime[31:0]};
      end else begin
        mtime <= mtime + 64'd1;
      end
      // Compare value, one word per write
      if (bus_we && bus_addr == reg_mtimecmp_lo) begin
        mtimecmp[31:0] <= bus_wdata;
      end
      if (bus_we && bus_addr == reg_mtimecmp_hi) begin
        mtimecmp[63:32] <= bus_wdata;
      end
    end
  end

  // Level interrupt while count has reached compare
  assign mtip = (mtime >= mtimecmp);

  // Read mux, zero for CSR indices
  always_comb begin
    case (bus_addr)
      reg_mtime_lo:    timer_rdata = mtime[31:0];
      reg_mtime_hi:    timer_rdata = mtime[63:32];
      reg_mtimecmp_lo: timer_rdata = mtimecmp[31:0];
      reg_mtimecmp_hi: timer_rdata = mtimecmp[63:32];
      default:         timer_rdata = '0;
    endcase
  end

endmodule

//--- source/interrupt_controller.sv
`timescale 1ns/100ps

module interrupt_controller import irq_pkg::*; (
  // Hardware sources
  input  logic            mtip,
  input  logic            msip,
  input  logic            seip,
  input  logic            meip,
  // CSR state
  input  logic [xlen-1:0] mie,
  input  logic [xlen-1:0] mip_current,
  input  logic [xlen-1:0] mideleg,
  input  logic [xlen-1:0] mstatus,
  input  logic [1:0]      priv,
  input  logic [63:0]     mtime,
  input  logic [xlen-1:0] stimecmp,
  input  logic [xlen-1:0] stimecmph,
  input  logic [xlen-1:0] menvcfgh,
  input  logic [xlen-1:0] mcounteren,
  // Merged pending bits
  output logic [xlen-1:0] mip_next,
  // Gated lines to the encoder
  output logic            irq_ssip,
  output logic            irq_msip,
  output logic            irq_stip,
  output logic            irq_mtip,
  output logic            irq_seip,
  output logic            irq_meip
);

  logic            sstc_on;
  logic            stip_cmp;
  logic [xlen-1:0] pending;
  logic            m_enabled;
  logic            s_enabled;
  logic [xlen-1:0] m_irqs;
  logic [xlen-1:0] s_irqs;
  logic [xlen-1:0] irqs;

  // ##################################################
  // Pending merge
  // ##################################################

  // Sstc drives STIP only with STCE and TM both set
  assign sstc_on  = menvcfgh[menvcfgh_stce_bit] & mcounteren[mcounteren_tm_bit];
  assign stip_cmp = (mtime >= {stimecmph, stimecmp});

  always_comb begin
    // Software bits kept, hardware bits reloaded
    mip_next           = mip_current;
    mip_next[msip_bit] = msip;
    mip_next[mtip_bit] = mtip;
    mip_next[seip_bit] = seip;
    mip_next[meip_bit] = meip;
    if (sstc_on) begin
      mip_next[stip_bit] = stip_cmp;
    end
  end

  // ##################################################
  // Enable, delegation and gating
  // ##################################################

  always_comb begin
    pending   = mip_next & mie;
    // Machine set always taken below M
    m_enabled = (priv != priv_m) || mstatus[mstatus_mie_bit];
    // Supervisor set, U always, S with SIE
    s_enabled = (priv == priv_u) || ((priv == priv_s) && mstatus[mstatus_sie_bit]);
    m_irqs    = pending & ~mideleg & {xlen{m_enabled}};
    s_irqs    = pending & mideleg & {xlen{s_enabled}};
    // Machine set wins when non-empty
    irqs      = (|m_irqs) ? m_irqs : s_irqs;
  end

  assign irq_ssip = irqs[ssip_bit];
  assign irq_msip = irqs[msip_bit];
  assign irq_stip = irqs[stip_bit];
  assign irq_mtip = irqs[mtip_bit];
  assign irq_seip = irqs[seip_bit];
  assign irq_meip = irqs[meip_bit];

endmodule

//--- source/irq_cause_encoder.sv
`timescale 1ns/100ps

module irq_cause_encoder import irq_pkg::*; (
  input  logic       irq_ssip,
  input  logic       irq_msip,
  input  logic       irq_stip,
  input  logic       irq_mtip,
  input  logic       irq_seip,
  input  logic       irq_meip,
  output logic       irq_take,
  output logic [3:0] irq_cause
);

  assign irq_take = irq_meip | irq_msip | irq_mtip | irq_seip | irq_ssip | irq_stip;

  // Fixed order, machine external first
  always_comb begin
    if (irq_meip) begin
      irq_cause = cause_mei;
    end else if (irq_msip) begin
      irq_cause = cause_msi;
    end else if (irq_mtip) begin
      irq_cause = cause_mti;
    end else if (irq_seip) begin
      irq_cause = cause_sei;
    end else if (irq_ssip) begin
      irq_cause = cause_ssi;
    end else if (irq_stip) begin
      irq_cause = cause_sti;
    end else begin
      irq_cause = 4'd0;
    end
  end

endmodule

//--- source/irq_subsystem.sv
`timescale 1ns/100ps

module irq_subsystem import irq_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // External interrupt pins
  input  logic              msip,
  input  logic              seip,
  input  logic              meip,
  // Hart CSR port
  input  logic              cpu_req,
  input  logic              cpu_we,
  input  logic [addr_w-1:0] cpu_addr,
  input  logic [xlen-1:0]   cpu_wdata,
  output logic              cpu_gnt,
  output logic [xlen-1:0]   cpu_rdata,
  output logic              cpu_rvalid,
  // Debug or host port
  input  logic              host_req,
  input  logic              host_we,
  input  logic [addr_w-1:0] host_addr,
  input  logic [xlen-1:0]   host_wdata,
  output logic              host_gnt,
  output logic [xlen-1:0]   host_rdata,
  output logic              host_rvalid,
  // To the hart
  output logic              irq_take,
  output logic [3:0]        irq_cause,
  output logic [5:0]        irq_lines
);

  logic              bus_we;
  logic [addr_w-1:0] bus_addr;
  logic [xlen-1:0]   bus_wdata;
  logic [xlen-1:0]   bus_rdata;
  logic [xlen-1:0]   csr_rdata;
  logic [xlen-1:0]   timer_rdata;
  logic [xlen-1:0]   mstatus;
  logic [xlen-1:0]   mie;
  logic [xlen-1:0]   mideleg;
  logic [xlen-1:0]   mip;
  logic [xlen-1:0]   mip_next;
  logic [1:0]        priv;
  logic [xlen-1:0]   menvcfgh;
  logic [xlen-1:0]   mcounteren;
  logic [xlen-1:0]   stimecmp;
  logic [xlen-1:0]   stimecmph;
  logic [63:0]       mtime;
  logic              mtip;
  logic              irq_ssip;
  logic              irq_msip;
  logic              irq_stip;
  logic              irq_mtip;
  logic              irq_seip;
  logic              irq_meip;

  // Targets drive zero outside their own indices
  assign bus_rdata = csr_rdata | timer_rdata;

  // Lines in mip bit order
  assign irq_lines = {irq_meip, irq_seip, irq_mtip, irq_stip, irq_msip, irq_ssip};

  reg_bus_arbiter u_arbiter (.*);

  irq_csr_bank u_csr_bank (.*);

  machine_timer u_timer (.*);

  interrupt_controller u_irq_ctrl (
    .mtip, .msip, .seip, .meip,
    .mie, .mip_current(mip), .mideleg, .mstatus, .priv, .mtime,
    .stimecmp, .stimecmph, .menvcfgh, .mcounteren,
    .mip_next,
    .irq_ssip, .irq_msip, .irq_stip, .irq_mtip, .irq_seip, .irq_meip
  );

  irq_cause_encoder u_encoder (.*);

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset low for 8 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- dv/irq_subsystem_chk.sv
`timescale 1ns/100ps

module irq_subsystem_chk (
  input logic clk,
  input logic rst_n,
  input logic cpu_req,
  input logic cpu_gnt,
  input logic cpu_rvalid,
  input logic host_req,
  input logic host_gnt,
  input logic host_rvalid
);

  // Failed properties so far
  int unsigned fail_count = 0;

  // One master on the bus at a time
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(cpu_gnt && host_gnt))
    else begin
      fail_count++;
      $error("cpu and host granted in the same cycle");
    end

  // Response pulse exactly one cycle after the grant
  a_rvalid_delay: assert property (@(posedge clk) disable iff (!rst_n)
    (cpu_rvalid == $past(cpu_gnt)) && (host_rvalid == $past(host_gnt)))
    else begin
      fail_count++;
      $error("rvalid does not follow gnt by one cycle");
    end

  // Grant only to a requesting master
  a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!cpu_gnt || cpu_req) && (!host_gnt || host_req))
    else begin
      fail_count++;
      $error("grant given without a request");
    end

endmodule

//--- dv/irq_subsystem_tb.sv
`timescale 1ns/100ps

module irq_subsystem_tb import irq_pkg::*; ();

  // Transactions over both masters
  localparam int n_txn = 300;
  // Twenty cycles per transaction plus reset
  localparam int watchdog_cycles = n_txn * 20 + 8;

  logic              clk;
  logic              rst_n;
  logic              msip;
  logic              seip;
  logic              meip;
  // Index 0 is the cpu port, 1 the host port
  logic              req [2];
  logic              we [2];
  logic [addr_w-1:0] addr [2];
  logic [xlen-1:0]   wdata [2];
  // Write first, then read back the same index
  logic              phase [2];
  logic              cpu_gnt;
  logic [xlen-1:0]   cpu_rdata;
  logic              cpu_rvalid;
  logic              host_gnt;
  logic [xlen-1:0]   host_rdata;
  logic              host_rvalid;
  logic              irq_take;
  logic [3:0]        irq_cause;
  logic [5:0]        irq_lines;

  // Reference model state
  logic [xlen-1:0]   m_mstatus;
  logic [xlen-1:0]   m_mie;
  logic [xlen-1:0]   m_mideleg;
  logic [xlen-1:0]   m_mip;
  logic [1:0]        m_priv;
  logic [xlen-1:0]   m_menvcfgh;
  logic [xlen-1:0]   m_mcounteren;
  logic [xlen-1:0]   m_stimecmp;
  logic [xlen-1:0]   m_stimecmph;
  logic [63:0]       m_mtime;
  logic [63:0]       m_mtimecmp;
  logic              m_last_host;
  logic [xlen-1:0]   m_rdata;
  logic              m_rv [2];

  integer            seed;
  int                issued;
  int                done_cnt;
  int                err_count;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  irq_subsystem DUT (
    .clk, .rst_n, .msip, .seip, .meip,
    .cpu_req(req[0]), .cpu_we(we[0]), .cpu_addr(addr[0]), .cpu_wdata(wdata[0]),
    .cpu_gnt, .cpu_rdata, .cpu_rvalid,
    .host_req(req[1]), .host_we(we[1]), .host_addr(addr[1]), .host_wdata(wdata[1]),
    .host_gnt, .host_rdata, .host_rvalid,
    .irq_take, .irq_cause, .irq_lines
  );

  bind reg_bus_arbiter irq_subsystem_chk u_chk (
    .clk(clk), .rst_n(rst_n),
    .cpu_req(cpu_req), .cpu_gnt(cpu_gnt), .cpu_rvalid(cpu_rvalid),
    .host_req(host_req), .host_gnt(host_gnt), .host_rvalid(host_rvalid)
  );

  // ##################################################
  // Reference model
  // ##################################################

  // Lone requester always wins
  // On contention the master not served last wins
  // Result is {host, cpu}
  function automatic logic [1:0] model_grant();
    if (req[0] && req[1]) begin
      return m_last_host ? 2'b01 : 2'b10;
    end
    return {req[1], req[0]};
  endfunction

  function automatic logic [xlen-1:0] model_read(input logic [addr_w-1:0] a);
    case (a)
      reg_mstatus:     return m_mstatus;
      reg_mie:         return m_mie;
      reg_mideleg:     return m_mideleg;
      reg_mip:         return m_mip;
      reg_priv:        return {30'd0, m_priv};
      reg_menvcfgh:    return m_menvcfgh;
      reg_mcounteren:  return m_mcounteren;
      reg_stimecmp:    return m_stimecmp;
      reg_stimecmph:   return m_stimecmph;
      reg_mtime_lo:    return m_mtime[31:0];
      reg_mtime_hi:    return m_mtime[63:32];
      reg_mtimecmp_lo: return m_mtimecmp[31:0];
      reg_mtimecmp_hi: return m_mtimecmp[63:32];
      default:         return '0;
    endcase
  endfunction

  // Pins reload the hardware bits, Sstc may take over STIP
  function automatic logic [xlen-1:0] model_mip_next();
    logic [xlen-1:0] v;
    v = m_mip;
    v[msip_bit] = msip;
    v[mtip_bit] = (m_mtime >= m_mtimecmp);
    v[seip_bit] = seip;
    v[meip_bit] = meip;
    if (m_menvcfgh[menvcfgh_stce_bit] && m_mcounteren[mcounteren_tm_bit]) begin
      v[stip_bit] = (m_mtime >= {m_stimecmph, m_stimecmp});
    end
    return v;
  endfunction

  // Enable, delegate, gate by privilege, machine set first
  function automatic logic [5:0] model_lines(input logic [xlen-1:0] mipn);
    logic [xlen-1:0] pend;
    logic [xlen-1:0] sel;
    logic            m_ok;
    logic            s_ok;
    pend = mipn & m_mie;
    m_ok = (m_priv != priv_m) || m_mstatus[mstatus_mie_bit];
    s_ok = (m_priv == priv_u) || (m_priv == priv_s && m_mstatus[mstatus_sie_bit]);
    sel  = pend & ~m_mideleg & {xlen{m_ok}};
    if (sel == '0) begin
      sel = pend & m_mideleg & {xlen{s_ok}};
    end
    return {sel[meip_bit], sel[seip_bit], sel[mtip_bit],
            sel[stip_bit], sel[msip_bit], sel[ssip_bit]};
  endfunction

  // Order MEI MSI MTI SEI SSI STI
  function automatic logic [3:0] model_cause(input logic [5:0] l);
    casez (l)
      6'b1?????: return 4'd11;
      6'b????1?: return 4'd3;
      6'b??1???: return 4'd7;
      6'b?1????: return 4'd9;
      6'b?????1: return 4'd1;
      6'b???1??: return 4'd5;
      default:   return 4'd0;
    endcase
  endfunction

  always @(posedge clk or negedge rst_n) begin : model_update
    logic [xlen-1:0]   mipn;
    logic [xlen-1:0]   wmask;
    logic [1:0]        g;
    logic              bwe;
    logic [addr_w-1:0] ba;
    logic [xlen-1:0]   bd;
    if (!rst_n) begin
      m_mstatus    <= '0;
      m_mie        <= '0;
      m_mideleg    <= '0;
      m_mip        <= '0;
      m_priv       <= priv_m;
      m_menvcfgh   <= '0;
      m_mcounteren <= '0;
      m_stimecmp   <= '1;
      m_stimecmph  <= '1;
      m_mtime      <= '0;
      m_mtimecmp   <= '1;
      // cpu goes first after reset
      m_last_host  <= 1'b1;
      m_rdata      <= '0;
      m_rv[0]      <= 1'b0;
      m_rv[1]      <= 1'b0;
    end else begin
      mipn = model_mip_next();
      g    = model_grant();
      bwe  = (g[0] && we[0]) || (g[1] && we[1]);
      ba   = g[1] ? addr[1] : addr[0];
      bd   = g[1] ? wdata[1] : wdata[0];
      // Read data taken before the write lands
      if (g != 2'b00) begin
        m_rdata     <= model_read(ba);
        m_last_host <= g[1];
      end
      m_rv[0] <= g[0];
      m_rv[1] <= g[1];
      m_mip   <= mipn;
      m_mtime <= m_mtime + 64'd1;
      if (bwe) begin
        case (ba)
          reg_mstatus:     m_mstatus    <= bd;
          reg_mie:         m_mie        <= bd;
          reg_mideleg:     m_mideleg    <= bd;
          reg_menvcfgh:    m_menvcfgh   <= bd;
          reg_mcounteren:  m_mcounteren <= bd;
          reg_stimecmp:    m_stimecmp   <= bd;
          reg_stimecmph:   m_stimecmph  <= bd;
          reg_mtime_lo:    m_mtime      <= {m_mtime[63:32], bd};
          reg_mtime_hi:    m_mtime      <= {bd, m_mtime[31:0]};
          reg_mtimecmp_lo: m_mtimecmp[31:0]  <= bd;
          reg_mtimecmp_hi: m_mtimecmp[63:32] <= bd;
          reg_mip: begin
            // SSIP always, STIP only with STCE clear
            wmask = mip_sw_mask;
            if (m_menvcfgh[menvcfgh_stce_bit]) begin
              wmask[stip_bit] = 1'b0;
            end
            m_mip <= (mipn & ~wmask) | (bd & wmask);
          end
          reg_priv: begin
            if (bd[1:0] != 2'd2) begin
              m_priv <= bd[1:0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // ##################################################
  // Checks and stimulus
  // ##################################################

  task automatic fail_run(input string what);
    err_count++;
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_outputs();
    logic [1:0] g;
    logic [5:0] lines;
    g     = model_grant();
    lines = model_lines(model_mip_next());
    assert (cpu_gnt === g[0] && host_gnt === g[1])
      else fail_run($sformatf("** Error at %0t: gnt cpu %b host %b, expected %b %b",
                              $time, cpu_gnt, host_gnt, g[0], g[1]));
    assert (cpu_rvalid === m_rv[0] && host_rvalid === m_rv[1])
      else fail_run($sformatf("** Error at %0t: rvalid cpu %b host %b, expected %b %b",
                              $time, cpu_rvalid, host_rvalid, m_rv[0], m_rv[1]));
    assert (!m_rv[0] || cpu_rdata === m_rdata)
      else fail_run($sformatf("** Error at %0t: cpu_rdata %h, expected %h",
                              $time, cpu_rdata, m_rdata));
    assert (!m_rv[1] || host_rdata === m_rdata)
      else fail_run($sformatf("** Error at %0t: host_rdata %h, expected %h",
                              $time, host_rdata, m_rdata));
    assert (irq_lines === lines)
      else fail_run($sformatf("** Error at %0t: irq_lines %b, expected %b",
                              $time, irq_lines, lines));
    assert (irq_take === (|lines) && irq_cause === model_cause(lines))
      else fail_run($sformatf("** Error at %0t: take %b cause %0d, expected %b %0d",
                              $time, irq_take, irq_cause, |lines, model_cause(lines)));
    assert (DUT.u_arbiter.u_chk.fail_count == 0)
      else fail_run("A bus protocol assertion on the arbiter failed");
  endtask

  // Timer compares land a few ticks ahead of mtime
  task automatic choose_wdata(input logic [addr_w-1:0] a, output logic [xlen-1:0] d);
    case (a)
      reg_mtimecmp_lo, reg_stimecmp: d = m_mtime[31:0] + ($random(seed) & 63);
      reg_mtimecmp_hi, reg_stimecmph, reg_mtime_hi: begin
        d = (($random(seed) & 3) == 0) ? '1 : '0;
      end
      reg_mtime_lo: d = $random(seed) & 255;
      reg_priv:     d = $random(seed) & 3;
      default:      d = $random(seed);
    endcase
  endtask

  // Response pulse ends a transaction, then maybe a new request
  task automatic step_master(input int m);
    logic rv;
    rv = (m == 0) ? cpu_rvalid : host_rvalid;
    if (rv) begin
      done_cnt++;
      req[m]   = 1'b0;
      phase[m] = ~phase[m];
    end
    if (!req[m] && issued < n_txn && ($random(seed) & 3) != 0) begin
      if (phase[m]) begin
        // Read back the index just written
        we[m] = 1'b0;
      end else begin
        we[m]   = 1'b1;
        addr[m] = addr_w'($random(seed));
        choose_wdata(addr[m], wdata[m]);
      end
      req[m] = 1'b1;
      issued++;
    end
  endtask

  initial begin
    seed      = 32'h12706142;
    issued    = 0;
    done_cnt  = 0;
    err_count = 0;
    msip      = 1'b0;
    seip      = 1'b0;
    meip      = 1'b0;
    for (int m = 0; m < 2; m++) begin
      req[m]   = 1'b0;
      we[m]    = 1'b0;
      addr[m]  = '0;
      wdata[m] = '0;
      phase[m] = 1'b0;
    end
    @(posedge rst_n);
    while (done_cnt < n_txn) begin
      @(negedge clk);
      check_outputs();
      step_master(0);
      step_master(1);
      // Occasional pin changes
      if (($random(seed) & 7) == 0) begin
        {meip, seip, msip} = 3'($random(seed));
      end
    end
    if (err_count == 0 && DUT.u_arbiter.u_chk.fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_cycles * 10);
    fail_run("Timeout: the transactions did not finish in time");
  end

endmodule

//--- src.f
source/irq_pkg.sv
source/reg_bus_arbiter.sv
source/irq_csr_bank.sv
source/machine_timer.sv
source/interrupt_controller.sv
source/irq_cause_encoder.sv
source/irq_subsystem.sv
dv/tb_clk_gen.sv
dv/irq_subsystem_chk.sv
dv/irq_subsystem_tb.sv

//--- Bender.yml
package:
  name: irq_subsystem

sources:
  # RTL in compile order, irq_subsystem is the top level
  - files:
      - source/irq_pkg.sv
      - source/reg_bus_arbiter.sv
      - source/irq_csr_bank.sv
      - source/machine_timer.sv
      - source/interrupt_controller.sv
      - source/irq_cause_encoder.sv
      - source/irq_subsystem.sv

  # Testbench, top module irq_subsystem_tb
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/irq_subsystem_chk.sv
      - dv/irq_subsystem_tb.sv
